//--- symb_rate_divider.f
+incdir+tb
src/symb_rate_pkg.sv
src/axis_if.sv
src/mmi_if.sv
src/symb_rate_regs.sv
src/symb_rate_repeater.sv
src/symb_rate_divider_top.sv
tb/tb_symb_rate_divider.sv

//--- tb/tb_symb_rate_model.svh
/* Testbench reference model */

`ifndef TB_SYMB_RATE_MODEL_SVH
`define TB_SYMB_RATE_MODEL_SVH

//////////////////////////////////////////////////
// Random numbers

// 32-bit LCG step
function automatic logic [31:0] lcg(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

//////////////////////////////////////////////////
// Reference model

// Expected output samples, oldest first
symb_rate_pkg::iq_sample_t exp_q[$];
// Rate index the model holds as active
logic [symb_rate_pkg::SYMB_RATE_SEL_NB-1:0] model_idx;

// Msps to index by the register map, full rate otherwise
function automatic logic [symb_rate_pkg::SYMB_RATE_SEL_NB-1:0] rate_index(
    input logic [symb_rate_pkg::MMI_DATA_NB-1:0] msps
);
    case (msps)
        32'd100: return symb_rate_pkg::TX_SYMB_RATE_QUARTER;
        32'd200: return symb_rate_pkg::TX_SYMB_RATE_HALF;
        default: return symb_rate_pkg::TX_SYMB_RATE_FULL;
    endcase
endfunction

// One accepted symbol, repeated by its hold count
task automatic push_expected(input symb_rate_pkg::iq_sample_t s);
    repeat (symb_rate_pkg::SYMB_RATE_DIV[model_idx]) exp_q.push_back(s);
endtask

//////////////////////////////////////////////////
// Compare tasks

task automatic check_sample(input string name, input symb_rate_pkg::iq_sample_t exp_s,
                            input symb_rate_pkg::iq_sample_t act_s);
    if (act_s !== exp_s) begin
        $display("[FAIL] %s expected %h actual %h", name, exp_s, act_s);
        abort_run();
    end
endtask

task automatic check_reg(input string name,
                         input logic [symb_rate_pkg::MMI_DATA_NB-1:0] exp_v,
                         input logic [symb_rate_pkg::MMI_DATA_NB-1:0] act_v);
    if (act_v !== exp_v) begin
        $display("[FAIL] %s expected %0d actual %0d", name, exp_v, act_v);
        abort_run();
    end
endtask

`endif

//--- tb/tb_symb_rate_divider.sv
/* Symbol rate divider testbench */

module tb_symb_rate_divider;

    localparam int CLK_PERIOD = 100;
    localparam logic [31:0] SEED = 32'hb45d68f3;
    localparam int NUM_SYMB = 200;
    localparam int BURST_SYMB = 30;
    // Output transfers of all stream tests plus register accesses
    localparam int PLANNED_XFERS = NUM_SYMB * 7 + BURST_SYMB * 8 + 64;
    localparam int TIMEOUT = (PLANNED_XFERS * 20 + 500) * CLK_PERIOD;

    logic                                   clk;
    logic                                   sresetn_mmi_interconnect;
    logic                                   s_tvalid;
    logic                                   s_tready;
    symb_rate_pkg::iq_sample_t              s_tdata;
    logic                                   m_tvalid;
    logic                                   m_tready;
    symb_rate_pkg::iq_sample_t              m_tdata;
    logic                                   mmi_wvalid;
    logic [symb_rate_pkg::MMI_ADDR_NB-1:0]  mmi_waddr;
    logic [symb_rate_pkg::MMI_DATA_NB-1:0]  mmi_wdata;
    logic                                   mmi_wready;
    logic                                   mmi_arvalid;
    logic [symb_rate_pkg::MMI_ADDR_NB-1:0]  mmi_raddr;
    logic                                   mmi_arready;
    logic                                   mmi_rvalid;
    logic [symb_rate_pkg::MMI_DATA_NB-1:0]  mmi_rdata;
    logic                                   mmi_rready;

    int          err_cnt = 0;
    string       cur_test = "reset";
    logic [31:0] stim_st;
    logic [31:0] bp_st;
    logic [31:0] test_rates [3] = '{32'd100, 32'd200, 32'd400};

    task automatic abort_run();
        err_cnt++;
        $display("Done: errors found");
        $fatal(1, "Stopped at first error");
    endtask

    `include "tb_symb_rate_model.svh"

    symb_rate_divider_top u_symb_rate_divider_top (.*);

    //////////////////////////////////////////////////
    // Clock, back-pressure, watchdog

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Output ready about three cycles in four
    initial begin
        bp_st = ~SEED;
        forever begin
            @(negedge clk);
            bp_st = lcg(bp_st);
            m_tready = (bp_st[31:30] != 2'b00);
        end
    end

    initial begin
        #(TIMEOUT);
        $display("Timeout: the tests did not finish within %0d time units", TIMEOUT);
        abort_run();
    end

    //////////////////////////////////////////////////
    // Stream monitor

    // Inputs change on the falling edge, so both sides are settled here
    always @(posedge clk) begin
        if (sresetn_mmi_interconnect) begin
            if (m_tvalid && m_tready) begin
                if (exp_q.size() == 0) begin
                    $display("Output sample appeared with none expected in %s", cur_test);
                    abort_run();
                end else begin
                    check_sample(cur_test, exp_q.pop_front(), m_tdata);
                end
            end
            if (s_tvalid && s_tready) push_expected(s_tdata);
        end
    end

    //////////////////////////////////////////////////
    // Bus and stream tasks

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
        @(negedge clk);
        mmi_wvalid = 1'b1;
        mmi_waddr  = addr;
        mmi_wdata  = data;
        do @(posedge clk); while (!mmi_wready);
        @(negedge clk);
        mmi_wvalid = 1'b0;
    endtask

    task automatic check_read(input string name, input logic [3:0] addr,
                              input logic [31:0] exp_v);
        @(negedge clk);
        mmi_arvalid = 1'b1;
        mmi_raddr   = addr;
        mmi_rready  = 1'b1;
        do @(posedge clk); while (!mmi_arready);
        @(negedge clk);
        mmi_arvalid = 1'b0;
        do @(posedge clk); while (!mmi_rvalid);
        check_reg(name, exp_v, mmi_rdata);
    endtask

    // Read stalled with rready low, data must stay put
    task automatic held_read(input string name, input logic [3:0] addr,
                             input logic [31:0] exp_v);
        logic [31:0] first;
        @(negedge clk);
        mmi_rready  = 1'b0;
        mmi_arvalid = 1'b1;
        mmi_raddr   = addr;
        do @(posedge clk); while (!mmi_arready);
        @(negedge clk);
        mmi_arvalid = 1'b0;
        // Other register on the address lines during the stall
        mmi_raddr   = (addr == symb_rate_pkg::ADDR_SYMB_RATE_SEL) ?
                      symb_rate_pkg::ADDR_SYMB_RATE_IDX : symb_rate_pkg::ADDR_SYMB_RATE_SEL;
        @(posedge clk);
        first = mmi_rdata;
        repeat (5) begin
            if (!mmi_rvalid) begin
                $display("Read data valid dropped while rready was low in %s", name);
                abort_run();
            end
            check_reg(name, first, mmi_rdata);
            @(posedge clk);
        end
        @(negedge clk);
        mmi_rready = 1'b1;
        @(posedge clk);
        if (!mmi_rvalid) begin
            $display("Read data valid missing when rready rose in %s", name);
            abort_run();
        end
        check_reg(name, exp_v, mmi_rdata);
    endtask

    // Input held idle around the write so the model rate is exact
    task automatic set_rate(input logic [31:0] msps);
        idle(3);
        reg_write(symb_rate_pkg::ADDR_SYMB_RATE_SEL, msps);
        model_idx = rate_index(msps);
        idle(3);
    endtask

    // Random symbols with random gaps of 0 to 3 cycles
    task automatic run_burst(input int count);
        for (int n = 0; n < count; n++) begin
            stim_st = lcg(stim_st);
            repeat (stim_st[17:16]) begin
                @(negedge clk);
                s_tvalid = 1'b0;
            end
            stim_st = lcg(stim_st);
            @(negedge clk);
            s_tvalid = 1'b1;
            s_tdata  = stim_st;
            do @(posedge clk); while (!s_tready);
        end
        @(negedge clk);
        s_tvalid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    //////////////////////////////////////////////////
    // Test sequence

    initial begin
        logic [31:0] odd_rate;
        sresetn_mmi_interconnect = 1'b0;
        s_tvalid    = 1'b0;
        s_tdata     = '0;
        m_tready    = 1'b1;
        mmi_wvalid  = 1'b0;
        mmi_waddr   = '0;
        mmi_wdata   = '0;
        mmi_arvalid = 1'b0;
        mmi_raddr   = '0;
        mmi_rready  = 1'b1;
        stim_st     = SEED;
        model_idx   = symb_rate_pkg::TX_SYMB_RATE_FULL;
        repeat (4) @(posedge clk);
        if (m_tvalid || s_tready || mmi_rvalid) begin
            $display("Stream or read outputs were active during reset");
            abort_run();
        end
        @(negedge clk);
        sresetn_mmi_interconnect = 1'b1;

        // Reset values
        check_read("reset_rate", symb_rate_pkg::ADDR_SYMB_RATE_SEL, 32'd400);
        check_read("reset_index", symb_rate_pkg::ADDR_SYMB_RATE_IDX, 32'd2);

        // Listed rates and their indices
        for (int k = 0; k < 3; k++) begin
            set_rate(test_rates[k]);
            check_read("rate_readback", symb_rate_pkg::ADDR_SYMB_RATE_SEL, test_rates[k]);
            check_read("rate_index", symb_rate_pkg::ADDR_SYMB_RATE_IDX,
                       32'(rate_index(test_rates[k])));
        end

        // Odd value is never a listed rate
        stim_st  = lcg(stim_st);
        odd_rate = stim_st | 32'd1;
        set_rate(odd_rate);
        check_read("unlisted_rate", symb_rate_pkg::ADDR_SYMB_RATE_SEL, odd_rate);
        check_read("unlisted_index", symb_rate_pkg::ADDR_SYMB_RATE_IDX, 32'd2);
        // A listed rate, so a leak into the rate register moves the index
        reg_write(symb_rate_pkg::ADDR_SYMB_RATE_IDX, 32'd100);
        idle(2);
        check_read("ro_index", symb_rate_pkg::ADDR_SYMB_RATE_IDX, 32'd2);
        reg_write(4'h7, 32'h0000_1234);
        check_read("unmapped_write", symb_rate_pkg::ADDR_SYMB_RATE_SEL, odd_rate);
        check_read("unmapped_read", 4'hA, 32'd0);

        // Long runs at each rate
        for (int k = 0; k < 3; k++) begin
            set_rate(test_rates[k]);
            cur_test = $sformatf("stream_%0d_msps", test_rates[k]);
            run_burst(NUM_SYMB);
            wait_drain();
        end

        // Rate changes between bursts, no drain in between
        cur_test = "rate_change";
        for (int k = 0; k < 3; k++) begin
            set_rate(test_rates[k]);
            run_burst(BURST_SYMB);
        end
        set_rate(odd_rate);
        run_burst(BURST_SYMB);
        wait_drain();

        // Stalled read
        set_rate(test_rates[1]);
        held_read("held_read", symb_rate_pkg::ADDR_SYMB_RATE_SEL, test_rates[1]);
        idle(2);

        if (err_cnt == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1, "Errors were reported");
        end
    end

endmodule

//--- src/symb_rate_divider_top.sv
/* TX symbol rate divider */

module symb_rate_divider_top (
    input  logic                                    clk,
    input  logic                                    sresetn_mmi_interconnect,

    // Symbols from the modulator
    input  logic                                    s_tvalid,
    output logic                                    s_tready,
    input  symb_rate_pkg::iq_sample_t               s_tdata,

    // Samples toward the DAC
    output logic                                    m_tvalid,
    input  logic                                    m_tready,
    output symb_rate_pkg::iq_sample_t               m_tdata,

    // Register write
    input  logic                                    mmi_wvalid,
    input  logic [symb_rate_pkg::MMI_ADDR_NB-1:0]   mmi_waddr,
    input  logic [symb_rate_pkg::MMI_DATA_NB-1:0]   mmi_wdata,
    output logic                                    mmi_wready,

    // Register read request
    input  logic                                    mmi_arvalid,
    input  logic [symb_rate_pkg::MMI_ADDR_NB-1:0]   mmi_raddr,
    output logic                                    mmi_arready,

    // Register read data
    output logic                                    mmi_rvalid,
    output logic [symb_rate_pkg::MMI_DATA_NB-1:0]   mmi_rdata,
    input  logic                                    mmi_rready
);

    //////////////////////////////////////////////////
    // Internal buses

    axis_if u_s_axis ();
    axis_if u_m_axis ();
    mmi_if  u_mmi ();

    // Rate index from registers to repeater
    logic [symb_rate_pkg::SYMB_RATE_SEL_NB-1:0] symb_rate_sel;

    //////////////////////////////////////////////////
    // Port to interface mapping

    // Input stream
    assign u_s_axis.tvalid = s_tvalid;
    assign u_s_axis.tdata  = s_tdata;
    assign s_tready        = u_s_axis.tready;

    // Output stream
    assign m_tvalid        = u_m_axis.tvalid;
    assign m_tdata         = u_m_axis.tdata;
    assign u_m_axis.tready = m_tready;

    // Register bus
    assign u_mmi.wvalid  = mmi_wvalid;
    assign u_mmi.waddr   = mmi_waddr;
    assign u_mmi.wdata   = mmi_wdata;
    assign mmi_wready    = u_mmi.wready;
    assign u_mmi.arvalid = mmi_arvalid;
    assign u_mmi.raddr   = mmi_raddr;
    assign mmi_arready   = u_mmi.arready;
    assign mmi_rvalid    = u_mmi.rvalid;
    assign mmi_rdata     = u_mmi.rdata;
    assign u_mmi.rready  = mmi_rready;

    //////////////////////////////////////////////////
    // Blocks

    // Rate register and index lookup
    symb_rate_regs u_regs (
        .clk                      (clk),
        .sresetn_mmi_interconnect (sresetn_mmi_interconnect),
        .mmi                      (u_mmi.slave),
        .symb_rate_sel            (symb_rate_sel)
    );

    // Symbol repeat stage
    symb_rate_repeater u_repeater (
        .clk                      (clk),
        .sresetn_mmi_interconnect (sresetn_mmi_interconnect),
        .symb_rate_sel            (symb_rate_sel),
        .s_axis                   (u_s_axis.slave),
        .m_axis                   (u_m_axis.master)
    );

endmodule

//--- src/symb_rate_repeater.sv
/* Symbol hold repeater */

module symb_rate_repeater (
    input  logic                                        clk,
    input  logic                                        sresetn_mmi_interconnect,
    input  logic [symb_rate_pkg::SYMB_RATE_SEL_NB-1:0]  symb_rate_sel,
    axis_if.slave                                       s_axis,
    axis_if.master                                      m_axis
);

    //////////////////////////////////////////////////
    // Hold count lookup

    // Out-of-range index falls back to the default rate
    function automatic logic [symb_rate_pkg::DIV_NB-1:0] sel_to_div(
        input logic [symb_rate_pkg::SYMB_RATE_SEL_NB-1:0] sel
    );
        logic [symb_rate_pkg::DIV_NB-1:0] div;
        case (sel)
            symb_rate_pkg::TX_SYMB_RATE_QUARTER: begin
                div = symb_rate_pkg::SYMB_RATE_DIV[symb_rate_pkg::TX_SYMB_RATE_QUARTER];
            end
            symb_rate_pkg::TX_SYMB_RATE_HALF: begin
                div = symb_rate_pkg::SYMB_RATE_DIV[symb_rate_pkg::TX_SYMB_RATE_HALF];
            end
            symb_rate_pkg::TX_SYMB_RATE_FULL: begin
                div = symb_rate_pkg::SYMB_RATE_DIV[symb_rate_pkg::TX_SYMB_RATE_FULL];
            end
            default: begin
                div = symb_rate_pkg::SYMB_RATE_DIV[symb_rate_pkg::DEFAULT_SYMB_RATE_SEL];
            end
        endcase
        return div;
    endfunction

    //////////////////////////////////////////////////
    // Signals

    // A symbol is being presented
    logic                               held;
    // Latched symbol and its hold count
    symb_rate_pkg::iq_sample_t          hold_data;
    logic [symb_rate_pkg::DIV_NB-1:0]   hold_div;
    // Completed output transfers of this symbol
    logic [symb_rate_pkg::DIV_NB-1:0]   rep_cnt;

    logic                               in_fire;
    logic                               out_fire;
    logic                               out_last;

    //////////////////////////////////////////////////
    // Handshake

    assign out_fire = m_axis.tvalid & m_axis.tready;
    // Final repeat of the held symbol
    assign out_last = out_fire & (rep_cnt == hold_div - 3'd1);

    // Free slot, or the slot empties this cycle
    assign s_axis.tready = sresetn_mmi_interconnect & (~held | out_last);
    assign in_fire       = s_axis.tvalid & s_axis.tready;

    assign m_axis.tvalid = held;
    assign m_axis.tdata  = hold_data;

    //////////////////////////////////////////////////
    // Repeat control

    // New symbol restarts the count; otherwise count output transfers
    always_ff @(posedge clk) begin
        if (!sresetn_mmi_interconnect) begin
            held    <= 1'b0;
            rep_cnt <= '0;
        end else if (in_fire) begin
            held    <= 1'b1;
            rep_cnt <= '0;
        end else if (out_last) begin
            held    <= 1'b0;
            rep_cnt <= '0;
        end else if (out_fire) begin
            rep_cnt <= rep_cnt + 3'd1;
        end
    end

    // Symbol and hold count, rate sampled at acceptance only
    always_ff @(posedge clk) begin
        if (in_fire) begin
            hold_data <= s_axis.tdata;
            hold_div  <= sel_to_div(symb_rate_sel);
        end
    end

    //////////////////////////////////////////////////
    // Checks

    // Output held under back-pressure
    a_out_stable : assert property (@(posedge clk) disable iff (!sresetn_mmi_interconnect)
        m_axis.tvalid && !m_axis.tready |=> m_axis.tvalid && $stable(m_axis.tdata))
        else $error("output changed under back-pressure");

    // Repeat count bounded by the latched hold count
    a_rep_in_range : assert property (@(posedge clk) disable iff (!sresetn_mmi_interconnect)
        held |-> rep_cnt < hold_div)
        else $error("repeat count past hold count");

endmodule

//--- src/symb_rate_regs.sv
/* Symbol rate register block */

module symb_rate_regs (
    input  logic                                        clk,
    input  logic                                        sresetn_mmi_interconnect,
    mmi_if.slave                                        mmi,
    output logic [symb_rate_pkg::SYMB_RATE_SEL_NB-1:0]  symb_rate_sel
);

    //////////////////////////////////////////////////
    // Msps to index lookup

    // Linear search of the rate table, default on no match
    function automatic logic [symb_rate_pkg::SYMB_RATE_SEL_NB-1:0] msps_to_sel(
        input logic [symb_rate_pkg::MMI_DATA_NB-1:0] msps
    );
        logic [symb_rate_pkg::SYMB_RATE_SEL_NB-1:0] sel;
        sel = symb_rate_pkg::DEFAULT_SYMB_RATE_SEL;
        for (int k = 0; k < symb_rate_pkg::NUM_TX_SYMB_RATES; k++) begin
            if (msps == symb_rate_pkg::SYMB_RATE_MSPS[k]) begin
                sel = k[symb_rate_pkg::SYMB_RATE_SEL_NB-1:0];
            end
        end
        return sel;
    endfunction

    //////////////////////////////////////////////////
    // Signals

    // Rate register, Msps as written by software
    logic [symb_rate_pkg::MMI_DATA_NB-1:0]      rate_reg;
    // Read-only copy of the chosen index
    logic [symb_rate_pkg::SYMB_RATE_SEL_NB-1:0] idx_reg;

    // Handshake qualifiers
    logic                                       wr_accept;
    logic                                       rd_accept;

    // Read mux output
    logic [symb_rate_pkg::MMI_DATA_NB-1:0]      rd_word;

    //////////////////////////////////////////////////
    // Handshakes

    // Writes always taken once out of reset
    assign mmi.wready  = sresetn_mmi_interconnect;
    // New read only when the data slot is free or draining
    assign mmi.arready = sresetn_mmi_interconnect & (~mmi.rvalid | mmi.rready);

    assign wr_accept = mmi.wvalid & mmi.wready;
    assign rd_accept = mmi.arvalid & mmi.arready;

    //////////////////////////////////////////////////
    // Register storage

    // Writes to the index or to unmapped addresses are dropped
    always_ff @(posedge clk) begin
        if (!sresetn_mmi_interconnect) begin
            rate_reg <= symb_rate_pkg::SYMB_RATE_MSPS[symb_rate_pkg::DEFAULT_SYMB_RATE_SEL];
        end else if (wr_accept && (mmi.waddr == symb_rate_pkg::ADDR_SYMB_RATE_SEL)) begin
            rate_reg <= mmi.wdata;
        end
    end

    // Index follows the stored rate through the lookup
    assign symb_rate_sel = msps_to_sel(rate_reg);

    // Index register lags the live select by one cycle
    always_ff @(posedge clk) begin
        if (!sresetn_mmi_interconnect) begin
            idx_reg <= symb_rate_pkg::DEFAULT_SYMB_RATE_SEL;
        end else begin
            idx_reg <= symb_rate_sel;
        end
    end

    //////////////////////////////////////////////////
    // Read path

    // Unknown addresses read as zero
    always_comb begin
        rd_word = '0;
        case (mmi.raddr)
            symb_rate_pkg::ADDR_SYMB_RATE_SEL: rd_word = rate_reg;
            symb_rate_pkg::ADDR_SYMB_RATE_IDX: rd_word = {
                {(symb_rate_pkg::MMI_DATA_NB - symb_rate_pkg::SYMB_RATE_SEL_NB){1'b0}},
                idx_reg
            };
            default: rd_word = '0;
        endcase
    end

    // Read valid, held until the master takes it
    always_ff @(posedge clk) begin
        if (!sresetn_mmi_interconnect) begin
            mmi.rvalid <= 1'b0;
        end else if (rd_accept) begin
            mmi.rvalid <= 1'b1;
        end else if (mmi.rready) begin
            mmi.rvalid <= 1'b0;
        end
    end

    // Read data, loaded only on an accepted request
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            mmi.rdata <= rd_word;
        end
    end

    //////////////////////////////////////////////////
    // Checks

    // Pending read data must not move while stalled
    a_rdata_stable : assert property (@(posedge clk) disable iff (!sresetn_mmi_interconnect)
        mmi.rvalid && !mmi.rready |=> mmi.rvalid && $stable(mmi.rdata))
        else $error("rdata changed while read stalled");

endmodule

//--- src/mmi_if.sv
/* Memory-mapped register bus */

interface mmi_if;

    // Write channel
    logic                                   wvalid;
    logic [symb_rate_pkg::MMI_ADDR_NB-1:0]  waddr;
    logic [symb_rate_pkg::MMI_DATA_NB-1:0]  wdata;
    logic                                   wready;

    // Read request channel
    logic                                   arvalid;
    logic [symb_rate_pkg::MMI_ADDR_NB-1:0]  raddr;
    logic                                   arready;

    // Read data channel
    logic                                   rvalid;
    logic [symb_rate_pkg::MMI_DATA_NB-1:0]  rdata;
    logic                                   rready;

    // Bus master, e.g. the CPU bridge
    modport master (
        output wvalid, waddr, wdata,
        input  wready,
        output arvalid, raddr,
        input  arready,
        input  rvalid, rdata,
        output rready
    );

    // Register block side
    modport slave (
        input  wvalid, waddr, wdata,
        output wready,
        input  arvalid, raddr,
        output arready,
        output rvalid, rdata,
        input  rready
    );

endinterface

//--- src/axis_if.sv
/* I/Q sample stream */

interface axis_if;

    // Handshake
    logic tvalid;
    logic tready;

    // One I/Q pair per transfer
    symb_rate_pkg::iq_sample_t tdata;

    // Source side
    modport master (
        output tvalid,
        output tdata,
        input  tready
    );

    // Sink side
    modport slave (
        input  tvalid,
        input  tdata,
        output tready
    );

endinterface

//--- src/symb_rate_pkg.sv
/* Symbol rate divider package */

package symb_rate_pkg;

    //////////////////////////////////////////////////
    // Rate selection

    // Number of selectable symbol rates
    localparam int NUM_TX_SYMB_RATES = 3;

    // Width of a rate index
    localparam int SYMB_RATE_SEL_NB = 2;

    // Rate indices
    localparam logic [SYMB_RATE_SEL_NB-1:0] TX_SYMB_RATE_QUARTER = 2'd0;
    localparam logic [SYMB_RATE_SEL_NB-1:0] TX_SYMB_RATE_HALF    = 2'd1;
    localparam logic [SYMB_RATE_SEL_NB-1:0] TX_SYMB_RATE_FULL    = 2'd2;

    // Reset value, also used for unknown rates
    localparam logic [SYMB_RATE_SEL_NB-1:0] DEFAULT_SYMB_RATE_SEL = TX_SYMB_RATE_FULL;

    //////////////////////////////////////////////////
    // Register map

    localparam int MMI_DATA_NB = 32;
    localparam int MMI_ADDR_NB = 4;

    // Rate in Msps, read/write
    localparam logic [MMI_ADDR_NB-1:0] ADDR_SYMB_RATE_SEL = 4'd0;
    // Chosen rate index, read-only
    localparam logic [MMI_ADDR_NB-1:0] ADDR_SYMB_RATE_IDX = 4'd1;

    // Symbol rate in Msps per index
    localparam logic [MMI_DATA_NB-1:0] SYMB_RATE_MSPS [NUM_TX_SYMB_RATES] =
        '{32'd100, 32'd200, 32'd400};

    //////////////////////////////////////////////////
    // Hold counts and samples

    // Width of a hold count
    localparam int DIV_NB = 3;

    // DAC cycles per symbol, by index
    localparam logic [DIV_NB-1:0] SYMB_RATE_DIV [NUM_TX_SYMB_RATES] = '{3'd4, 3'd2, 3'd1};

    // Width of one I or Q component
    localparam int SAMPLE_NB = 16;

    // I in the upper half, Q in the lower half
    typedef struct packed {
        logic signed [SAMPLE_NB-1:0] i;
        logic signed [SAMPLE_NB-1:0] q;
    } iq_sample_t;

endpackage
